//--- hw/rv_bypass_pkg.sv
`default_nettype none

package rv_bypass_pkg;

    localparam int xlen           = 64;
    localparam int reg_addr_width = 5;
    localparam int reg_depth      = 32;

    localparam logic [6:0] op_reg = 7'b0110011; // R-type alu
    localparam logic [6:0] op_imm = 7'b0010011; // I-type alu

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub

    localparam int alu_op_width = 3;

    localparam logic [alu_op_width-1:0] alu_add = 3'd0;
    localparam logic [alu_op_width-1:0] alu_sub = 3'd1;
    localparam logic [alu_op_width-1:0] alu_and = 3'd2;
    localparam logic [alu_op_width-1:0] alu_or  = 3'd3;
    localparam logic [alu_op_width-1:0] alu_xor = 3'd4;
    localparam logic [alu_op_width-1:0] alu_slt = 3'd5;

    // one instruction word, two views
    typedef union packed {
        struct packed {
            logic [6:0]                funct7;
            logic [reg_addr_width-1:0] rs2;
            logic [reg_addr_width-1:0] rs1;
            logic [2:0]                funct3;
            logic [reg_addr_width-1:0] rd;
            logic [6:0]                opcode;
        } r_fields;
        struct packed {
            logic [11:0]               imm12;
            logic [reg_addr_width-1:0] rs1;
            logic [2:0]                funct3;
            logic [reg_addr_width-1:0] rd;
            logic [6:0]                opcode;
        } i_fields;
    } instr_t;

endpackage

`default_nettype wire

//--- hw/reg_file.sv
`default_nettype none

module reg_file (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire [rv_bypass_pkg::reg_addr_width-1:0] raddr1,
    input  wire [rv_bypass_pkg::reg_addr_width-1:0] raddr2,
    output logic [rv_bypass_pkg::xlen-1:0]          rdata1,
    output logic [rv_bypass_pkg::xlen-1:0]          rdata2,
    input  wire                                    we,
    input  wire [rv_bypass_pkg::reg_addr_width-1:0] waddr,
    input  wire [rv_bypass_pkg::xlen-1:0]           wdata
);

    logic [rv_bypass_pkg::xlen-1:0] regs [0:rv_bypass_pkg::reg_depth-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_bypass_pkg::reg_depth; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // no write-through, WB is covered by forwarding
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // x0 stays zero across every write since reset
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        raddr1 == '0 |-> rdata1 == '0
    ) else $error("x0 read back nonzero");

endmodule

`default_nettype wire

//--- hw/instr_decode.sv
`default_nettype none

module instr_decode (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire                                      instr_valid,
    input  wire [31:0]                               instr,
    output logic                                     id_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0] rs1,
    output logic [rv_bypass_pkg::reg_addr_width-1:0] rs2,
    output logic [rv_bypass_pkg::reg_addr_width-1:0] rd,
    output logic [rv_bypass_pkg::xlen-1:0]           imm,
    output logic [rv_bypass_pkg::alu_op_width-1:0]   alu_op,
    output logic                                     use_imm
);

    rv_bypass_pkg::instr_t id_instr;
    logic                  id_word_valid;
    logic                  legal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_word_valid <= 1'b0;
            id_instr      <= '0;
        end else begin
            id_word_valid <= instr_valid;
            id_instr      <= instr;
        end
    end

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        alu_op  = rv_bypass_pkg::alu_add;
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        case (id_instr.r_fields.opcode)
            rv_bypass_pkg::op_reg: begin
                rs1 = id_instr.r_fields.rs1;
                rs2 = id_instr.r_fields.rs2;
                rd  = id_instr.r_fields.rd;
                if (id_instr.r_fields.funct7 == rv_bypass_pkg::f7_base) begin
                    legal = 1'b1;
                    case (id_instr.r_fields.funct3)
                        rv_bypass_pkg::f3_add_sub: alu_op = rv_bypass_pkg::alu_add;
                        rv_bypass_pkg::f3_slt:     alu_op = rv_bypass_pkg::alu_slt;
                        rv_bypass_pkg::f3_xor:     alu_op = rv_bypass_pkg::alu_xor;
                        rv_bypass_pkg::f3_or:      alu_op = rv_bypass_pkg::alu_or;
                        rv_bypass_pkg::f3_and:     alu_op = rv_bypass_pkg::alu_and;
                        default:                   legal = 1'b0;
                    endcase
                end else if (id_instr.r_fields.funct7 == rv_bypass_pkg::f7_alt &&
                             id_instr.r_fields.funct3 == rv_bypass_pkg::f3_add_sub) begin
                    legal  = 1'b1;
                    alu_op = rv_bypass_pkg::alu_sub;
                end
            end
            rv_bypass_pkg::op_imm: begin
                use_imm = 1'b1;
                rs1     = id_instr.i_fields.rs1;
                rd      = id_instr.i_fields.rd; // rs2 left at 0, nothing to forward
                legal   = 1'b1;
                case (id_instr.i_fields.funct3)
                    rv_bypass_pkg::f3_add_sub: alu_op = rv_bypass_pkg::alu_add;
                    rv_bypass_pkg::f3_xor:     alu_op = rv_bypass_pkg::alu_xor;
                    rv_bypass_pkg::f3_or:      alu_op = rv_bypass_pkg::alu_or;
                    rv_bypass_pkg::f3_and:     alu_op = rv_bypass_pkg::alu_and;
                    default:                   legal = 1'b0; // slti and shifts not supported
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    assign id_valid = id_word_valid && legal; // illegal word becomes a bubble
    assign imm = {{(rv_bypass_pkg::xlen-12){id_instr.i_fields.imm12[11]}},
                  id_instr.i_fields.imm12};

endmodule

`default_nettype wire

//--- hw/operand_forward.sv
`default_nettype none

module operand_forward (
    input  wire [rv_bypass_pkg::reg_addr_width-1:0] rs1,
    input  wire [rv_bypass_pkg::reg_addr_width-1:0] rs2,
    input  wire [rv_bypass_pkg::xlen-1:0]           rs1_data,
    input  wire [rv_bypass_pkg::xlen-1:0]           rs2_data,
    input  wire                                    ex_valid,
    input  wire [rv_bypass_pkg::reg_addr_width-1:0] ex_rd,
    input  wire [rv_bypass_pkg::xlen-1:0]           ex_result,
    input  wire                                    mem_valid,
    input  wire [rv_bypass_pkg::reg_addr_width-1:0] mem_rd,
    input  wire [rv_bypass_pkg::xlen-1:0]           mem_result,
    input  wire                                    wb_valid,
    input  wire [rv_bypass_pkg::reg_addr_width-1:0] wb_rd,
    input  wire [rv_bypass_pkg::xlen-1:0]           wb_data,
    output logic [rv_bypass_pkg::xlen-1:0]          op_a,
    output logic [rv_bypass_pkg::xlen-1:0]          op_b
);

    logic ex_hit_a;
    logic mem_hit_a;
    logic wb_hit_a;
    logic ex_hit_b;
    logic mem_hit_b;
    logic wb_hit_b;

    // a stage matches when valid and its rd is the source
    assign ex_hit_a  = ex_valid  && ex_rd  == rs1;
    assign mem_hit_a = mem_valid && mem_rd == rs1;
    assign wb_hit_a  = wb_valid  && wb_rd  == rs1;
    assign ex_hit_b  = ex_valid  && ex_rd  == rs2;
    assign mem_hit_b = mem_valid && mem_rd == rs2;
    assign wb_hit_b  = wb_valid  && wb_rd  == rs2;

    always_comb begin
        if (rs1 == '0) begin
            op_a = '0;
        end else if (ex_hit_a) begin // youngest first
            op_a = ex_result;
        end else if (mem_hit_a) begin
            op_a = mem_result;
        end else if (wb_hit_a) begin
            op_a = wb_data;
        end else begin
            op_a = rs1_data;
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            op_b = '0;
        end else if (ex_hit_b) begin
            op_b = ex_result;
        end else if (mem_hit_b) begin
            op_b = mem_result;
        end else if (wb_hit_b) begin
            op_b = wb_data;
        end else begin
            op_b = rs2_data;
        end
    end

    // alu_exec zeroes the result of an x0 write
    always_comb begin
        a_no_x0_escape: assert (
            !(ex_valid  && ex_rd  == '0 && ex_result  != '0) &&
            !(mem_valid && mem_rd == '0 && mem_result != '0) &&
            !(wb_valid  && wb_rd  == '0 && wb_data    != '0)
        ) else $error("nonzero result tagged with rd x0");
    end

endmodule

`default_nettype wire

//--- hw/alu_exec.sv
`default_nettype none

module alu_exec (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire                                    id_valid,
    input  wire [rv_bypass_pkg::reg_addr_width-1:0] rd,
    input  wire [rv_bypass_pkg::alu_op_width-1:0]   alu_op,
    input  wire                                    use_imm,
    input  wire [rv_bypass_pkg::xlen-1:0]           imm,
    input  wire [rv_bypass_pkg::xlen-1:0]           op_a,
    input  wire [rv_bypass_pkg::xlen-1:0]           op_b,
    output logic                                    ex_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0] ex_rd,
    output logic [rv_bypass_pkg::xlen-1:0]          ex_result
);

    logic [rv_bypass_pkg::xlen-1:0] src_b;
    logic [rv_bypass_pkg::xlen-1:0] alu_res;

    assign src_b = use_imm ? imm : op_b;

    always_comb begin
        case (alu_op)
            rv_bypass_pkg::alu_add: alu_res = op_a + src_b;
            rv_bypass_pkg::alu_sub: alu_res = op_a - src_b;
            rv_bypass_pkg::alu_and: alu_res = op_a & src_b;
            rv_bypass_pkg::alu_or:  alu_res = op_a | src_b;
            rv_bypass_pkg::alu_xor: alu_res = op_a ^ src_b;
            rv_bypass_pkg::alu_slt: alu_res = {{(rv_bypass_pkg::xlen-1){1'b0}},
                                               $signed(op_a) < $signed(src_b)};
            default:                alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            ex_rd     <= '0;
            ex_result <= '0;
        end else begin
            ex_valid  <= id_valid;
            ex_rd     <= rd;
            ex_result <= (rd == '0) ? '0 : alu_res; // x0 result never leaves EX
        end
    end

endmodule

`default_nettype wire

//--- hw/writeback_stage.sv
`default_nettype none

module writeback_stage (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire                                      ex_valid,
    input  wire [rv_bypass_pkg::reg_addr_width-1:0]  ex_rd,
    input  wire [rv_bypass_pkg::xlen-1:0]            ex_result,
    output logic                                     mem_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0] mem_rd,
    output logic [rv_bypass_pkg::xlen-1:0]           mem_result,
    output logic                                     wb_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0] wb_rd,
    output logic [rv_bypass_pkg::xlen-1:0]           wb_data,
    output logic                                     we,
    output logic [rv_bypass_pkg::reg_addr_width-1:0] waddr,
    output logic [rv_bypass_pkg::xlen-1:0]           wdata
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid  <= 1'b0;
            mem_rd     <= '0;
            mem_result <= '0;
            wb_valid   <= 1'b0;
            wb_rd      <= '0;
            wb_data    <= '0;
        end else begin
            mem_valid  <= ex_valid;
            mem_rd     <= ex_rd;
            mem_result <= ex_result; // x0 already zero out of EX
            wb_valid   <= mem_valid;
            wb_rd      <= mem_rd;
            wb_data    <= mem_result;
        end
    end

    assign we    = wb_valid && wb_rd != '0;
    assign waddr = wb_rd;
    assign wdata = wb_data;

    a_we_from_mem: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> wb_valid && $past(mem_valid) && $past(mem_rd) == waddr
    ) else $error("register write without a retiring instruction");

endmodule

`default_nettype wire

//--- hw/rv_bypass_top.sv
`default_nettype none

module rv_bypass_top (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire                                      instr_valid,
    input  wire [31:0]                               instr,
    output logic                                     wb_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0] wb_rd,
    output logic [rv_bypass_pkg::xlen-1:0]           wb_data
);

    logic                                     id_valid;
    logic [rv_bypass_pkg::reg_addr_width-1:0] rs1;
    logic [rv_bypass_pkg::reg_addr_width-1:0] rs2;
    logic [rv_bypass_pkg::reg_addr_width-1:0] rd;
    logic [rv_bypass_pkg::xlen-1:0]           imm;
    logic [rv_bypass_pkg::alu_op_width-1:0]   alu_op;
    logic                                     use_imm;
    logic [rv_bypass_pkg::xlen-1:0]           rs1_data;
    logic [rv_bypass_pkg::xlen-1:0]           rs2_data;
    logic [rv_bypass_pkg::xlen-1:0]           op_a;
    logic [rv_bypass_pkg::xlen-1:0]           op_b;
    logic                                     ex_valid;
    logic [rv_bypass_pkg::reg_addr_width-1:0] ex_rd;
    logic [rv_bypass_pkg::xlen-1:0]           ex_result;
    logic                                     mem_valid;
    logic [rv_bypass_pkg::reg_addr_width-1:0] mem_rd;
    logic [rv_bypass_pkg::xlen-1:0]           mem_result;
    logic                                     we;
    logic [rv_bypass_pkg::reg_addr_width-1:0] waddr;
    logic [rv_bypass_pkg::xlen-1:0]           wdata;

    instr_decode u_decode (
        .clk, .rst_n, .instr_valid, .instr,
        .id_valid, .rs1, .rs2, .rd, .imm, .alu_op, .use_imm
    );

    reg_file u_regs (
        .clk, .rst_n,
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we, .waddr, .wdata
    );

    operand_forward u_fwd (
        .rs1, .rs2, .rs1_data, .rs2_data,
        .ex_valid, .ex_rd, .ex_result,
        .mem_valid, .mem_rd, .mem_result,
        .wb_valid, .wb_rd, .wb_data,
        .op_a, .op_b
    );

    alu_exec u_alu (
        .clk, .rst_n, .id_valid, .rd, .alu_op, .use_imm, .imm, .op_a, .op_b,
        .ex_valid, .ex_rd, .ex_result
    );

    writeback_stage u_wb (
        .clk, .rst_n, .ex_valid, .ex_rd, .ex_result,
        .mem_valid, .mem_rd, .mem_result,
        .wb_valid, .wb_rd, .wb_data,
        .we, .waddr, .wdata
    );

endmodule

`default_nettype wire

//--- bench/rv_bypass_tb.sv
`default_nettype none

module rv_bypass_tb;

    localparam int clk_period     = 20;
    localparam int reset_cycles   = 16;
    localparam int directed_slots = 80; // upper bound on directed issue and idle slots
    localparam int random_count   = 300;
    localparam int timeout_cycles = reset_cycles + directed_slots + random_count + 50;

    logic                                     clk = 1'b0;
    logic                                     rst_n;
    logic                                     instr_valid;
    logic [31:0]                              instr;
    logic                                     wb_valid;
    logic [rv_bypass_pkg::reg_addr_width-1:0] wb_rd;
    logic [rv_bypass_pkg::xlen-1:0]           wb_data;

    logic [rv_bypass_pkg::xlen-1:0] ref_regs [0:31]; // architectural state
    logic [4:0]                     exp_rd_q [$];
    logic [63:0]                    exp_data_q [$];
    string                          exp_name_q [$];
    string                          test_name;
    int                             seed = 32'h5778;
    int                             checked;

    rv_bypass_top dut (
        .clk, .rst_n, .instr_valid, .instr,
        .wb_valid, .wb_rd, .wb_data
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic rv_bypass_pkg::instr_t r_type(input logic [6:0] f7,
            input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2);
        rv_bypass_pkg::instr_t w;
        w.r_fields.funct7 = f7;
        w.r_fields.rs2    = rs2;
        w.r_fields.rs1    = rs1;
        w.r_fields.funct3 = f3;
        w.r_fields.rd     = rd;
        w.r_fields.opcode = rv_bypass_pkg::op_reg;
        return w;
    endfunction

    function automatic rv_bypass_pkg::instr_t i_type(input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm12);
        rv_bypass_pkg::instr_t w;
        w.i_fields.imm12  = imm12;
        w.i_fields.rs1    = rs1;
        w.i_fields.funct3 = f3;
        w.i_fields.rd     = rd;
        w.i_fields.opcode = rv_bypass_pkg::op_imm;
        return w;
    endfunction

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // mostly alu opcodes over x0..x7 plus some funct and opcode garbage
    function automatic rv_bypass_pkg::instr_t random_instr();
        rv_bypass_pkg::instr_t w;
        int                    pick;
        w    = $random(seed);
        pick = rand_below(100);
        w.r_fields.rd  = 5'(rand_below(8));
        w.r_fields.rs1 = 5'(rand_below(8));
        if (pick < 45) begin
            w.r_fields.opcode = rv_bypass_pkg::op_reg;
            w.r_fields.rs2    = 5'(rand_below(8));
            pick = rand_below(100);
            if (pick < 75) begin
                w.r_fields.funct7 = 7'b0000000;
            end else if (pick < 92) begin
                w.r_fields.funct7 = 7'b0100000;
            end
        end else if (pick < 90) begin
            w.r_fields.opcode = rv_bypass_pkg::op_imm;
        end
        return w;
    endfunction

    // executes one word in order and returns 1 when it retires
    function automatic logic ref_execute(input rv_bypass_pkg::instr_t w,
            output logic [4:0] exp_rd, output logic [63:0] exp_data);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] res;
        logic        legal;
        legal  = 1'b0;
        res    = '0;
        exp_rd = w.r_fields.rd;
        a      = ref_regs[w.r_fields.rs1];
        if (w.r_fields.opcode == 7'b0110011) begin
            b = ref_regs[w.r_fields.rs2];
            legal = 1'b1;
            case ({w.r_fields.funct7, w.r_fields.funct3})
                {7'b0000000, 3'b000}: res = a + b;
                {7'b0100000, 3'b000}: res = a - b;
                {7'b0000000, 3'b010}: res = {63'b0, $signed(a) < $signed(b)};
                {7'b0000000, 3'b100}: res = a ^ b;
                {7'b0000000, 3'b110}: res = a | b;
                {7'b0000000, 3'b111}: res = a & b;
                default:              legal = 1'b0;
            endcase
        end else if (w.r_fields.opcode == 7'b0010011) begin
            b = {{52{w.i_fields.imm12[11]}}, w.i_fields.imm12};
            legal = 1'b1;
            case (w.i_fields.funct3)
                3'b000:  res = a + b;
                3'b100:  res = a ^ b;
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: legal = 1'b0;
            endcase
        end
        if (legal && exp_rd != 5'd0) begin
            ref_regs[exp_rd] = res;
        end
        exp_data = (exp_rd == 5'd0) ? 64'd0 : res;
        return legal;
    endfunction

    task automatic issue(input rv_bypass_pkg::instr_t w);
        logic [4:0]  e_rd;
        logic [63:0] e_data;
        logic        legal;
        @(posedge clk);
        #2;
        instr_valid = 1'b1;
        instr       = w;
        legal = ref_execute(w, e_rd, e_data);
        if (legal) begin
            exp_rd_q.push_back(e_rd);
            exp_data_q.push_back(e_data);
            exp_name_q.push_back(test_name);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            instr_valid = 1'b0;
            instr       = $random(seed); // garbage while not valid
        end
    endtask

    always @(negedge clk) begin
        logic [4:0]  e_rd;
        logic [63:0] e_data;
        string       e_name;
        if (rst_n && wb_valid) begin
            assert (exp_rd_q.size() > 0) else begin
                $display("writeback to x%0d seen with no instruction outstanding", wb_rd);
                $display("Test failed");
                $fatal(1, "unexpected writeback");
            end
            if (exp_rd_q.size() > 0) begin
                e_rd   = exp_rd_q.pop_front();
                e_data = exp_data_q.pop_front();
                e_name = exp_name_q.pop_front();
                assert (wb_rd == e_rd) else begin
                    $display("MISMATCH %s rd expected %0d actual %0d", e_name, e_rd, wb_rd);
                    $display("Test failed");
                    $fatal(1, "writeback rd wrong");
                end
                assert (wb_data == e_data) else begin
                    $display("MISMATCH %s data expected %h actual %h", e_name, e_data, wb_data);
                    $display("Test failed");
                    $fatal(1, "writeback data wrong");
                end
                checked++;
            end
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("timeout after %0d cycles with %0d results outstanding",
                 timeout_cycles, exp_rd_q.size());
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        checked     = 0;
        test_name   = "reset";
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_name = "regfile";
        issue(i_type(3'b000, 5'd1, 5'd0, 12'h123));
        issue(i_type(3'b000, 5'd2, 5'd0, 12'hfff)); // -1
        issue(i_type(3'b000, 5'd3, 5'd0, 12'h800));
        issue(i_type(3'b000, 5'd4, 5'd0, 12'h07f));
        issue(i_type(3'b000, 5'd10, 5'd0, 12'h001)); // unrelated spacers
        issue(i_type(3'b000, 5'd11, 5'd0, 12'h002));
        issue(i_type(3'b000, 5'd12, 5'd0, 12'h003));
        issue(r_type(7'h00, 3'b111, 5'd13, 5'd1, 5'd2)); // and
        issue(r_type(7'h00, 3'b110, 5'd14, 5'd3, 5'd4)); // or
        issue(r_type(7'h00, 3'b010, 5'd15, 5'd3, 5'd4)); // slt
        issue(r_type(7'h20, 3'b000, 5'd16, 5'd4, 5'd1)); // sub
        issue(r_type(7'h00, 3'b100, 5'd17, 5'd2, 5'd3)); // xor

        test_name = "fwd_ex";
        issue(i_type(3'b000, 5'd5, 5'd0, 12'h007));
        issue(i_type(3'b000, 5'd5, 5'd5, 12'h003));
        issue(r_type(7'h00, 3'b000, 5'd6, 5'd5, 5'd5));
        issue(r_type(7'h20, 3'b000, 5'd7, 5'd6, 5'd5));
        issue(r_type(7'h00, 3'b100, 5'd8, 5'd7, 5'd6));
        issue(r_type(7'h00, 3'b010, 5'd9, 5'd8, 5'd7));

        test_name = "fwd_mem";
        issue(i_type(3'b000, 5'd20, 5'd0, 12'h064));
        issue(i_type(3'b000, 5'd21, 5'd0, 12'h001));
        issue(r_type(7'h00, 3'b000, 5'd22, 5'd20, 5'd1)); // x20 from MEM
        issue(i_type(3'b110, 5'd23, 5'd21, 12'h0f0));     // ori with x21 from MEM

        test_name = "fwd_wb";
        issue(i_type(3'b000, 5'd24, 5'd0, 12'hffb));
        issue(i_type(3'b000, 5'd25, 5'd0, 12'h006));
        issue(i_type(3'b000, 5'd26, 5'd0, 12'h007));
        issue(r_type(7'h00, 3'b100, 5'd27, 5'd24, 5'd25)); // x24 from WB
        issue(i_type(3'b111, 5'd28, 5'd24, 12'h0ff));      // andi

        test_name = "priority";
        issue(i_type(3'b000, 5'd12, 5'd0, 12'h00b));
        issue(i_type(3'b000, 5'd12, 5'd0, 12'h016));
        issue(i_type(3'b000, 5'd12, 5'd0, 12'h021));
        issue(r_type(7'h00, 3'b000, 5'd13, 5'd12, 5'd12)); // youngest x12 twice
        issue(r_type(7'h20, 3'b000, 5'd14, 5'd13, 5'd12));

        test_name = "x0";
        issue(i_type(3'b000, 5'd0, 5'd1, 12'h005));
        issue(r_type(7'h00, 3'b000, 5'd15, 5'd0, 5'd0));
        issue(i_type(3'b000, 5'd0, 5'd0, 12'hfff));
        issue(r_type(7'h00, 3'b110, 5'd16, 5'd0, 5'd1));
        issue(r_type(7'h20, 3'b000, 5'd0, 5'd1, 5'd2));
        issue(r_type(7'h00, 3'b111, 5'd17, 5'd0, 5'd1)); // x0 right behind in EX

        test_name = "bubble";
        issue(i_type(3'b000, 5'd18, 5'd0, 12'h009));
        issue(32'h0000_3083); // load opcode
        idle(2);
        issue(r_type(7'h20, 3'b110, 5'd18, 5'd18, 5'd18)); // bad funct7
        issue(r_type(7'h00, 3'b000, 5'd19, 5'd18, 5'd18));
        issue(i_type(3'b010, 5'd19, 5'd0, 12'h001)); // slti unsupported
        idle(1);
        issue(r_type(7'h01, 3'b000, 5'd20, 5'd19, 5'd18)); // mul unsupported
        issue(r_type(7'h00, 3'b100, 5'd20, 5'd19, 5'd18));
        idle(3);

        test_name = "random";
        repeat (random_count) begin
            issue(random_instr());
        end
        idle(6); // three-cycle latency plus room for a stray writeback

        $display("%0d writebacks checked", checked);
        if (exp_rd_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d expected results never written back", exp_rd_q.size());
            $display("Test failed");
            $fatal(1, "results left unchecked");
        end
    end

endmodule

`default_nettype wire

//--- rv_bypass.f
hw/rv_bypass_pkg.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/operand_forward.sv
hw/alu_exec.sv
hw/writeback_stage.sv
hw/rv_bypass_top.sv
bench/rv_bypass_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rv_bypass testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f rv_bypass.f \
    --top-module rv_bypass_tb \
    -o rv_bypass_sim

./obj_dir/rv_bypass_sim
